// File: all.f
+incdir+source
source/soc_dbg_pkg.sv
source/apb_per_bridge.sv
source/dbg_regs.sv
source/soc_watchdog.sv
source/soc_rst_ctrl.sv
source/soc_dbg_domain.sv
sim/tb_soc_dbg_domain.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_soc_dbg_domain
RTL_TOP    ?= soc_dbg_domain
FLIST      ?= all.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ps -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/tb_soc_dbg_domain.sv
// *************************************************
// background kicks every 16 cycles, so the timeout
// must exceed 16, SOC_DBG_RST_SYNC must be 2 or more
// *************************************************
`timescale 1ns/1ps
`include "soc_dbg_params.svh"

module tb_soc_dbg_domain;

  localparam int CLK_PERIOD = 40;
  localparam int TIMEOUT = `SOC_DBG_WD_TIMEOUT;
  localparam int SYNC_LEN = `SOC_DBG_RST_SYNC;
  localparam int NR_RAND = 8;
  // transfers take four cycles with the idle cycle
  localparam int TRANSFERS = 4 * NR_RAND + 32;
  localparam int RUN_CYCLES = 4 * TRANSFERS + 3 * TIMEOUT + `SOC_DBG_WD_RST_CYCLES + 64;
  localparam soc_dbg_pkg::hart_mask_t SEL_MASK = `SOC_DBG_SEL_HARTS;
  // nscratch 2, dataaccess, datasize, dataaddr at DATA0
  localparam soc_dbg_pkg::data_t HARTINFO_EXP = {8'h00, 4'd2, 3'b000, 1'b1,
    4'(`SOC_DBG_DATA_COUNT), 12'(`SOC_DBG_ADDR_DATA0)};

  // dut side
  logic s_soc_clk;
  logic s_soc_rstn;
  soc_dbg_pkg::apb_req_t apb_req;
  soc_dbg_pkg::apb_rsp_t apb_rsp;
  logic wd_kick;
  soc_dbg_pkg::hart_mask_t debug_req;
  logic dmactive;
  logic fc_rstn;
  logic acc;

  // register model
  soc_dbg_pkg::data_t data_m [`SOC_DBG_DATA_COUNT];
  logic dmactive_m;
  logic ndmreset_m;
  logic haltreq_m;
  soc_dbg_pkg::hart_sel_t hartsel_m;

  // values expected at the next pready
  soc_dbg_pkg::data_t exp_rdata;
  logic exp_dmactive;
  soc_dbg_pkg::hart_mask_t exp_debug_req;
  logic exp_ndmreset;
  // ndmreset release tracking
  logic rel_pending;
  logic [SYNC_LEN-1:0] rel_hist;

  // kick generator and test phases
  logic kick_en;
  logic [3:0] kick_cnt;
  int since_kick;
  logic wd_phase;
  logic hold_phase;
  logic [31:0] lcg_state;
  soc_dbg_pkg::data_t rnd0;
  soc_dbg_pkg::data_t rnd1;

  assign acc = apb_req.psel && apb_req.penable;

  soc_dbg_domain UUT (
    .s_soc_clk   (s_soc_clk),
    .s_soc_rstn  (s_soc_rstn),
    .apb_req_i   (apb_req),
    .apb_rsp_o   (apb_rsp),
    .wd_kick_i   (wd_kick),
    .debug_req_o (debug_req),
    .dmactive_o  (dmactive),
    .fc_rstn_o   (fc_rstn)
  );

  initial begin
    s_soc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) s_soc_clk = ~s_soc_clk;
  end

  // *************************************************
  // helpers
  // *************************************************
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // haltreq 31, hartsel 17:16, ndmreset 1, dmactive 0
  function automatic soc_dbg_pkg::data_t dmcontrol_word(input logic halt,
      input soc_dbg_pkg::hart_sel_t hs, input logic ndm, input logic act);
    return {halt, 13'b0, hs, 14'b0, ndm, act};
  endfunction

  function automatic soc_dbg_pkg::hart_mask_t debug_req_model();
    if (dmactive_m && haltreq_m) begin
      return (soc_dbg_pkg::hart_mask_t'(1) << hartsel_m) & SEL_MASK;
    end
    return '0;
  endfunction

  function automatic soc_dbg_pkg::data_t expected_read(input soc_dbg_pkg::addr_t addr);
    case (addr)
      `SOC_DBG_ADDR_DATA0: return data_m[0];
      `SOC_DBG_ADDR_DATA1: return data_m[1];
      `SOC_DBG_ADDR_DMCONTROL: return dmcontrol_word(haltreq_m, hartsel_m, ndmreset_m,
                                                     dmactive_m);
      `SOC_DBG_ADDR_HARTINFO: return HARTINFO_EXP;
      `SOC_DBG_ADDR_HARTMASK: return soc_dbg_pkg::data_t'(SEL_MASK);
      default: return '0;
    endcase
  endfunction

  task automatic model_write(input soc_dbg_pkg::addr_t addr, input soc_dbg_pkg::data_t wdata);
    case (addr)
      `SOC_DBG_ADDR_DATA0: data_m[0] = wdata;
      `SOC_DBG_ADDR_DATA1: data_m[1] = wdata;
      // dmactive clear wipes the other fields
      `SOC_DBG_ADDR_DMCONTROL: begin
        dmactive_m = wdata[0];
        ndmreset_m = wdata[0] & wdata[1];
        haltreq_m  = wdata[0] & wdata[31];
        hartsel_m  = wdata[0] ? wdata[17:16] : '0;
      end
      default: ;
    endcase
  endtask

  // setup, access, hold until pready
  task automatic bus_transfer(input logic wr, input soc_dbg_pkg::addr_t addr,
      input soc_dbg_pkg::data_t wdata);
    @(posedge s_soc_clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    exp_dmactive    <= dmactive_m;
    exp_debug_req   <= debug_req_model();
    exp_ndmreset    <= ndmreset_m;
    @(posedge s_soc_clk);
    apb_req.penable <= 1'b1;
    @(posedge s_soc_clk);
    while (!apb_rsp.pready) @(posedge s_soc_clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
    rel_pending     <= 1'b0;
  endtask

  task automatic apb_write(input soc_dbg_pkg::addr_t addr, input soc_dbg_pkg::data_t wdata);
    logic old_ndm;
    old_ndm = ndmreset_m;
    model_write(addr, wdata);
    exp_rdata   <= '0;
    rel_pending <= old_ndm && !ndmreset_m;
    bus_transfer(1'b1, addr, wdata);
  endtask

  task automatic apb_read(input soc_dbg_pkg::addr_t addr);
    exp_rdata   <= expected_read(addr);
    rel_pending <= 1'b0;
    bus_transfer(1'b0, addr, '0);
  endtask

  task automatic stop_run();
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at the first failure");
  endtask

  // *************************************************
  // kicks and reference counters
  // *************************************************
  initial begin
    wd_kick    = 1'b0;
    kick_cnt   = '0;
    since_kick = 0;
    rel_hist   = '0;
    forever begin
      @(posedge s_soc_clk);
      kick_cnt   <= kick_cnt + 1'b1;
      wd_kick    <= kick_en && (kick_cnt == 4'hf);
      // cycles since the last sampled kick
      since_kick <= wd_kick ? 0 : since_kick + 1;
      rel_hist   <= {rel_hist[SYNC_LEN-2:0], apb_rsp.pready && rel_pending};
    end
  end

  // run limit
  initial begin
    #(2 * RUN_CYCLES * CLK_PERIOD);
    $display("timeout, the run did not finish within %0d cycles", 2 * RUN_CYCLES);
    stop_run();
  end

  // *************************************************
  // checks
  // *************************************************
  a_rdata : assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    apb_rsp.pready |-> apb_rsp.prdata == exp_rdata)
    else begin
      $display("ERROR: prdata expected %h got %h", exp_rdata, $sampled(apb_rsp.prdata));
      stop_run();
    end

  // pready one cycle after penable rises, only then
  a_pready_follows : assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    $rose(acc) |=> apb_rsp.pready)
    else begin
      $display("pready did not rise one cycle after penable");
      stop_run();
    end

  a_pready_place : assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    apb_rsp.pready |-> acc && $past(acc) && !$past(acc, 2))
    else begin
      $display("pready high outside the first access cycle after penable");
      stop_run();
    end

  a_dmactive : assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    apb_rsp.pready |-> dmactive == exp_dmactive)
    else begin
      $display("ERROR: dmactive_o expected %h got %h", exp_dmactive, $sampled(dmactive));
      stop_run();
    end

  a_debug_req : assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    apb_rsp.pready |-> debug_req == exp_debug_req)
    else begin
      $display("ERROR: debug_req_o expected %h got %h", exp_debug_req, $sampled(debug_req));
      stop_run();
    end

  a_ndm_assert : assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    (apb_rsp.pready && exp_ndmreset) |-> !fc_rstn)
    else begin
      $display("ERROR: fc_rstn_o expected %h got %h", 1'b0, $sampled(fc_rstn));
      stop_run();
    end

  // release window after ndmreset clears
  a_ndm_hold : assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    ((apb_rsp.pready && rel_pending) || (|rel_hist[SYNC_LEN-2:0])) |-> !fc_rstn)
    else begin
      $display("ERROR: fc_rstn_o expected %h got %h", 1'b0, $sampled(fc_rstn));
      stop_run();
    end

  a_ndm_release : assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    rel_hist[SYNC_LEN-1] |-> fc_rstn)
    else begin
      $display("ERROR: fc_rstn_o expected %h got %h", 1'b1, $sampled(fc_rstn));
      stop_run();
    end

  a_wd_early : assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    (wd_phase && $fell(fc_rstn)) |-> since_kick == TIMEOUT)
    else begin
      $display("fc reset fell %0d cycles after the last kick", since_kick);
      stop_run();
    end

  a_wd_late : assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    (wd_phase && since_kick == TIMEOUT) |-> !fc_rstn)
    else begin
      $display("fc reset still high at the watchdog timeout");
      stop_run();
    end

  a_wd_hold : assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    hold_phase |-> fc_rstn)
    else begin
      $display("watchdog reset the fc during a debug session");
      stop_run();
    end

  // *************************************************
  // stimulus
  // *************************************************
  initial begin
    apb_req       = '0;
    s_soc_rstn    = 1'b0;
    kick_en       = 1'b1;
    wd_phase      = 1'b0;
    hold_phase    = 1'b0;
    exp_rdata     = '0;
    exp_dmactive  = 1'b0;
    exp_debug_req = '0;
    exp_ndmreset  = 1'b0;
    rel_pending   = 1'b0;
    dmactive_m    = 1'b0;
    ndmreset_m    = 1'b0;
    haltreq_m     = 1'b0;
    hartsel_m     = '0;
    lcg_state     = 32'hdbcd;
    repeat (2) @(posedge s_soc_clk);
    s_soc_rstn <= 1'b1;
    while (!fc_rstn) @(posedge s_soc_clk);

    // data registers and unmapped space
    for (int i = 0; i < NR_RAND; i++) begin
      lcg_state = lcg_next(lcg_state);
      rnd0 = lcg_state;
      lcg_state = lcg_next(lcg_state);
      rnd1 = lcg_state;
      apb_write(`SOC_DBG_ADDR_DATA0, rnd0);
      apb_write(`SOC_DBG_ADDR_DATA1, rnd1);
      apb_read(`SOC_DBG_ADDR_DATA0);
      apb_read(`SOC_DBG_ADDR_DATA1);
    end
    apb_read(12'h000);
    apb_read(12'h018);
    apb_write(12'h020, rnd0);
    apb_read(12'h020);
    apb_read(12'hFFC);
    apb_read(`SOC_DBG_ADDR_DATA0);

    // read-only words
    apb_read(`SOC_DBG_ADDR_HARTINFO);
    apb_read(`SOC_DBG_ADDR_HARTMASK);
    apb_write(`SOC_DBG_ADDR_HARTINFO, rnd1);
    apb_write(`SOC_DBG_ADDR_HARTMASK, ~rnd1);
    apb_read(`SOC_DBG_ADDR_HARTINFO);
    apb_read(`SOC_DBG_ADDR_HARTMASK);

    // halt request per hart slot, then dmactive clear
    for (int h = 0; h < `SOC_DBG_NR_HARTS; h++) begin
      apb_write(`SOC_DBG_ADDR_DMCONTROL,
                dmcontrol_word(1'b1, soc_dbg_pkg::hart_sel_t'(h), 1'b0, 1'b1));
      apb_read(`SOC_DBG_ADDR_DMCONTROL);
    end
    apb_write(`SOC_DBG_ADDR_DMCONTROL, dmcontrol_word(1'b1, '0, 1'b0, 1'b1));
    apb_write(`SOC_DBG_ADDR_DMCONTROL, dmcontrol_word(1'b1, 2'd2, 1'b1, 1'b0));
    apb_read(`SOC_DBG_ADDR_DMCONTROL);

    // ndmreset assert and release
    apb_write(`SOC_DBG_ADDR_DMCONTROL, dmcontrol_word(1'b0, '0, 1'b1, 1'b1));
    apb_read(`SOC_DBG_ADDR_DMCONTROL);
    apb_write(`SOC_DBG_ADDR_DMCONTROL, dmcontrol_word(1'b0, '0, 1'b0, 1'b1));
    repeat (SYNC_LEN + 2) @(posedge s_soc_clk);

    // no kicks during a debug session
    kick_en    <= 1'b0;
    hold_phase <= 1'b1;
    repeat (2 * TIMEOUT) @(posedge s_soc_clk);
    hold_phase <= 1'b0;
    kick_en    <= 1'b1;
    apb_write(`SOC_DBG_ADDR_DMCONTROL, '0);

    // watchdog expiry with kicks stopped
    // last kick lands after dmactive clears
    while (!wd_kick) @(posedge s_soc_clk);
    kick_en  <= 1'b0;
    wd_phase <= 1'b1;
    while (fc_rstn) @(posedge s_soc_clk);
    wd_phase <= 1'b0;
    kick_en  <= 1'b1;
    while (!fc_rstn) @(posedge s_soc_clk);
    repeat (4) @(posedge s_soc_clk);

    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: source/soc_dbg_domain.sv
// *************************************************
// debug and reset slice of the soc domain
// single clock, apb debug bus only
// *************************************************
`timescale 1ns/1ps

module soc_dbg_domain (
  input  logic                    s_soc_clk,
  input  logic                    s_soc_rstn,
  input  soc_dbg_pkg::apb_req_t   apb_req_i,
  output soc_dbg_pkg::apb_rsp_t   apb_rsp_o,
  input  logic                    wd_kick_i,
  output soc_dbg_pkg::hart_mask_t debug_req_o,
  output logic                    dmactive_o,
  output logic                    fc_rstn_o
);

  // *************************************************
  // signals
  // *************************************************
  soc_dbg_pkg::per_req_t s_per_req;
  soc_dbg_pkg::per_rsp_t s_per_rsp;
  // active debug session
  logic s_dmactive;
  logic s_ndmreset;
  logic s_wd_expired;

  assign dmactive_o = s_dmactive;

  // *************************************************
  // apb to peripheral
  // *************************************************
  apb_per_bridge i_apb_per_bridge (
    .s_soc_clk  (s_soc_clk),
    .s_soc_rstn (s_soc_rstn),
    .apb_req_i  (apb_req_i),
    .apb_rsp_o  (apb_rsp_o),
    .per_req_o  (s_per_req),
    .per_rsp_i  (s_per_rsp)
  );

  // debug registers, on the global reset
  dbg_regs i_dbg_regs (
    .s_soc_clk   (s_soc_clk),
    .s_soc_rstn  (s_soc_rstn),
    .per_req_i   (s_per_req),
    .per_rsp_o   (s_per_rsp),
    .debug_req_o (debug_req_o),
    .dmactive_o  (s_dmactive),
    .ndmreset_o  (s_ndmreset)
  );

  // *************************************************
  // watchdog and fc reset
  // *************************************************
  soc_watchdog i_soc_watchdog (
    .s_soc_clk    (s_soc_clk),
    .s_soc_rstn   (s_soc_rstn),
    .wd_kick_i    (wd_kick_i),
    .dmactive_i   (s_dmactive),
    .wd_expired_o (s_wd_expired)
  );

  soc_rst_ctrl i_soc_rst_ctrl (
    .s_soc_clk    (s_soc_clk),
    .s_soc_rstn   (s_soc_rstn),
    .ndmreset_i   (s_ndmreset),
    .wd_expired_i (s_wd_expired),
    .fc_rstn_o    (fc_rstn_o)
  );

endmodule

// File: source/soc_rst_ctrl.sv
// *************************************************
// causes must be glitch free flop outputs
// needs SOC_DBG_RST_SYNC of 2 or more
// *************************************************
`timescale 1ns/1ps
`include "soc_dbg_params.svh"

module soc_rst_ctrl (
  input  logic s_soc_clk,
  input  logic s_soc_rstn,
  input  logic ndmreset_i,
  input  logic wd_expired_i,
  output logic fc_rstn_o
);

  localparam int unsigned SYNC_LEN = `SOC_DBG_RST_SYNC;

  // low while any reset cause is present
  logic causes_rstn;
  // release chain
  logic [SYNC_LEN-1:0] sync_q;

  assign causes_rstn = s_soc_rstn & ~ndmreset_i & ~wd_expired_i;

  // assert at once, release after SYNC_LEN edges
  always_ff @(posedge s_soc_clk or negedge causes_rstn) begin
    if (!causes_rstn) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[SYNC_LEN-2:0], 1'b1};
    end
  end

  // last stage is the fc reset
  assign fc_rstn_o = sync_q[SYNC_LEN-1];

endmodule

// File: source/soc_watchdog.sv
// *************************************************
// kicks ignored during the expiry pulse
// count frozen while a debug session is active
// *************************************************
`timescale 1ns/1ps
`include "soc_dbg_params.svh"

module soc_watchdog (
  input  logic s_soc_clk,
  input  logic s_soc_rstn,
  input  logic wd_kick_i,
  input  logic dmactive_i,
  output logic wd_expired_o
);

  localparam int unsigned TIMEOUT  = `SOC_DBG_WD_TIMEOUT;
  localparam int unsigned RST_LEN  = `SOC_DBG_WD_RST_CYCLES;
  localparam int unsigned CNT_W    = $clog2(TIMEOUT);

  // shared by timeout and pulse length
  logic [CNT_W-1:0] cnt_q;
  logic expired_q;

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      cnt_q     <= '0;
      expired_q <= 1'b0;
    end else if (expired_q) begin
      // fixed length pulse, then restart from zero
      if (cnt_q == CNT_W'(RST_LEN - 1)) begin
        cnt_q     <= '0;
        expired_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end else if (wd_kick_i) begin
      cnt_q <= '0;
    end else if (!dmactive_i) begin
      // last counting cycle raises the pulse
      if (cnt_q == CNT_W'(TIMEOUT - 1)) begin
        cnt_q     <= '0;
        expired_q <= 1'b1;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign wd_expired_o = expired_q;

  // no expiry out of a debug session
  a_no_expiry_in_debug : assert property (
    @(posedge s_soc_clk) disable iff (!s_soc_rstn)
    $rose(wd_expired_o) |-> !$past(dmactive_i)
  );

endmodule

// File: source/dbg_regs.sv
// *************************************************
// response one cycle after req, no error response
// unmapped reads give zero, unmapped writes dropped
// *************************************************
`timescale 1ns/1ps
`include "soc_dbg_params.svh"

module dbg_regs (
  input  logic                    s_soc_clk,
  input  logic                    s_soc_rstn,
  input  soc_dbg_pkg::per_req_t   per_req_i,
  output soc_dbg_pkg::per_rsp_t   per_rsp_o,
  output soc_dbg_pkg::hart_mask_t debug_req_o,
  output logic                    dmactive_o,
  output logic                    ndmreset_o
);

  localparam int unsigned DATA_IDX_W = $clog2(`SOC_DBG_DATA_COUNT);
  localparam soc_dbg_pkg::hart_mask_t SEL_MASK = `SOC_DBG_SEL_HARTS;

  // data registers
  soc_dbg_pkg::data_t data_q [`SOC_DBG_DATA_COUNT];
  logic [DATA_IDX_W-1:0] data_idx;
  logic data_hit;
  // dmcontrol fields
  logic dmactive_q;
  logic ndmreset_q;
  logic haltreq_q;
  soc_dbg_pkg::hart_sel_t hartsel_q;
  soc_dbg_pkg::data_t dmcontrol_word;
  // response
  soc_dbg_pkg::data_t rd_data;
  soc_dbg_pkg::data_t rdata_q;
  logic r_valid_q;
  logic ctrl_we;

  // *************************************************
  // address decode
  // *************************************************
  always_comb begin
    data_hit = 1'b1;
    data_idx = '0;
    case (per_req_i.addr)
      `SOC_DBG_ADDR_DATA0: data_idx = DATA_IDX_W'(0);
      `SOC_DBG_ADDR_DATA1: data_idx = DATA_IDX_W'(1);
      default: data_hit = 1'b0;
    endcase
  end

  assign ctrl_we = per_req_i.req && per_req_i.we &&
                   (per_req_i.addr == `SOC_DBG_ADDR_DMCONTROL);

  // haltreq 31, hartsel 17:16, ndmreset 1, dmactive 0
  assign dmcontrol_word = {haltreq_q, 13'b0, hartsel_q, 14'b0, ndmreset_q, dmactive_q};

  always_comb begin
    rd_data = '0;
    case (per_req_i.addr)
      `SOC_DBG_ADDR_DATA0, `SOC_DBG_ADDR_DATA1: rd_data = data_q[data_idx];
      `SOC_DBG_ADDR_DMCONTROL: rd_data = dmcontrol_word;
      `SOC_DBG_ADDR_HARTINFO: rd_data = soc_dbg_pkg::data_t'(soc_dbg_pkg::HARTINFO_VALUE);
      `SOC_DBG_ADDR_HARTMASK: rd_data = soc_dbg_pkg::data_t'(SEL_MASK);
      default: rd_data = '0;
    endcase
  end

  // *************************************************
  // registers
  // *************************************************
  // byte enabled data writes
  always_ff @(posedge s_soc_clk) begin
    if (per_req_i.req && per_req_i.we && data_hit) begin
      for (int b = 0; b < $bits(soc_dbg_pkg::be_t); b++) begin
        if (per_req_i.be[b]) begin
          data_q[data_idx][8*b +: 8] <= per_req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // dmactive clear wipes the whole control word
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      dmactive_q <= 1'b0;
      ndmreset_q <= 1'b0;
      haltreq_q  <= 1'b0;
      hartsel_q  <= '0;
    end else if (ctrl_we) begin
      dmactive_q <= per_req_i.wdata[0];
      ndmreset_q <= per_req_i.wdata[0] & per_req_i.wdata[1];
      haltreq_q  <= per_req_i.wdata[0] & per_req_i.wdata[31];
      hartsel_q  <= per_req_i.wdata[0] ? per_req_i.wdata[17:16] : '0;
    end
  end

  // registered response, zero data on writes
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= per_req_i.req;
    end
  end

  always_ff @(posedge s_soc_clk) begin
    rdata_q <= (per_req_i.req && !per_req_i.we) ? rd_data : '0;
  end

  assign per_rsp_o.r_valid = r_valid_q;
  assign per_rsp_o.rdata   = rdata_q;

  // *************************************************
  // outputs
  // *************************************************
  // one-hot of hartsel, only existing harts
  assign debug_req_o = (dmactive_q && haltreq_q) ?
                       ((soc_dbg_pkg::hart_mask_t'(1) << hartsel_q) & SEL_MASK) : '0;
  assign dmactive_o  = dmactive_q;
  assign ndmreset_o  = ndmreset_q;

  // req is a single cycle pulse
  a_req_single_pulse : assert property (
    @(posedge s_soc_clk) disable iff (!s_soc_rstn)
    per_req_i.req |=> !per_req_i.req
  );

endmodule

// File: source/apb_per_bridge.sv
// *************************************************
// one transfer in flight, no pslverr
// master must drop penable after pready
// *************************************************
`timescale 1ns/1ps

module apb_per_bridge (
  input  logic                  s_soc_clk,
  input  logic                  s_soc_rstn,
  input  soc_dbg_pkg::apb_req_t apb_req_i,
  output soc_dbg_pkg::apb_rsp_t apb_rsp_o,
  output soc_dbg_pkg::per_req_t per_req_o,
  input  soc_dbg_pkg::per_rsp_t per_rsp_i
);

  soc_dbg_pkg::bridge_state_e state_q;
  soc_dbg_pkg::bridge_state_e state_d;
  // apb access phase
  logic access;

  assign access = apb_req_i.psel && apb_req_i.penable;

  // *************************************************
  // fsm
  // *************************************************
  always_comb begin
    state_d = state_q;
    case (state_q)
      // first access cycle issues the request
      soc_dbg_pkg::BR_IDLE: begin
        if (access) begin
          state_d = soc_dbg_pkg::BR_WAIT;
        end
      end
      // wait for the registered response
      soc_dbg_pkg::BR_WAIT: begin
        if (per_rsp_i.r_valid) begin
          state_d = soc_dbg_pkg::BR_IDLE;
        end
      end
      default: state_d = soc_dbg_pkg::BR_IDLE;
    endcase
  end

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      state_q <= soc_dbg_pkg::BR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // *************************************************
  // request and response
  // *************************************************
  // single pulse, full word access
  assign per_req_o.req   = (state_q == soc_dbg_pkg::BR_IDLE) && access;
  assign per_req_o.we    = apb_req_i.pwrite;
  assign per_req_o.addr  = apb_req_i.paddr;
  assign per_req_o.be    = '1;
  assign per_req_o.wdata = apb_req_i.pwdata;

  // pready only on the response strobe
  assign apb_rsp_o.pready = (state_q == soc_dbg_pkg::BR_WAIT) && per_rsp_i.r_valid;
  assign apb_rsp_o.prdata = per_rsp_i.rdata;

  // response must land inside the access phase
  a_pready_in_access : assert property (
    @(posedge s_soc_clk) disable iff (!s_soc_rstn)
    apb_rsp_o.pready |-> (apb_req_i.psel && apb_req_i.penable)
  );

endmodule

// File: source/soc_dbg_pkg.sv
// *************************************************
// shared types of the debug slice, sized by the
// defines of soc_dbg_params.svh
// *************************************************
`include "soc_dbg_params.svh"

package soc_dbg_pkg;

  // plain vectors
  typedef logic [`SOC_DBG_ADDR_W-1:0] addr_t;
  typedef logic [`SOC_DBG_DATA_W-1:0] data_t;
  typedef logic [`SOC_DBG_DATA_W/8-1:0] be_t;
  typedef logic [`SOC_DBG_NR_HARTS-1:0] hart_mask_t;
  typedef logic [$clog2(`SOC_DBG_NR_HARTS)-1:0] hart_sel_t;

  // apb debug bus
  typedef struct packed {
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    data_t prdata;
    logic  pready;
  } apb_rsp_t;

  // peripheral side, implicit grant
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    be_t   be;
    data_t wdata;
  } per_req_t;

  typedef struct packed {
    logic  r_valid;
    data_t rdata;
  } per_rsp_t;

  // riscv debug spec hartinfo layout
  typedef struct packed {
    logic [7:0]  zero1;
    logic [3:0]  nscratch;
    logic [2:0]  zero0;
    logic        dataaccess;
    logic [3:0]  datasize;
    logic [11:0] dataaddr;
  } hartinfo_t;

  // two scratch regs, data regs memory mapped at DATA0
  localparam hartinfo_t HARTINFO_VALUE = '{
    zero1:      8'h00,
    nscratch:   4'd2,
    zero0:      3'b000,
    dataaccess: 1'b1,
    datasize:   4'(`SOC_DBG_DATA_COUNT),
    dataaddr:   12'(`SOC_DBG_ADDR_DATA0)
  };

  typedef enum logic {
    BR_IDLE,
    BR_WAIT
  } bridge_state_e;

endpackage

// File: source/soc_dbg_params.svh
// *************************************************
// one hart slot per mask bit, all register offsets
// are word aligned and fit in SOC_DBG_ADDR_W bits
// *************************************************
`ifndef SOC_DBG_PARAMS_SVH
`define SOC_DBG_PARAMS_SVH

// bus widths
`define SOC_DBG_ADDR_W 12
`define SOC_DBG_DATA_W 32

// harts, fc on slot 0 and one cluster core on slot 2
`define SOC_DBG_NR_HARTS 4
`define SOC_DBG_SEL_HARTS 4'b0101
`define SOC_DBG_DATA_COUNT 2

// register byte offsets
`define SOC_DBG_ADDR_DATA0 12'h010
`define SOC_DBG_ADDR_DATA1 12'h014
`define SOC_DBG_ADDR_DMCONTROL 12'h040
`define SOC_DBG_ADDR_HARTINFO 12'h048
`define SOC_DBG_ADDR_HARTMASK 12'h04C

// watchdog and reset release, in s_soc_clk cycles
`define SOC_DBG_WD_TIMEOUT 64
`define SOC_DBG_WD_RST_CYCLES 4
`define SOC_DBG_RST_SYNC 2

`endif
